/* hw/axil_pkg.sv */
package axil_pkg;

    // ------------------------------
    // bus widths
    // ------------------------------

    // byte address, only bits 11:2 are decoded
    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // ------------------------------
    // slave state machine
    // ------------------------------

    typedef enum logic [2:0] {
        st_idle,
        st_aw,
        st_w,
        st_wresp,
        st_rd_fetch,
        st_rd_resp
    } axil_state_e;

    // one-cycle register write, word address
    typedef struct packed {
        logic        en;
        logic [11:2] addr;
        axil_data_t  data;
    } reg_wr_t;

    // one-cycle register read fetch
    typedef struct packed {
        logic        en;
        logic [11:2] addr;
    } reg_rd_t;

endpackage

/* hw/hdc_pkg.sv */
package hdc_pkg;

    // ------------------------------
    // hypervector geometry
    // ------------------------------

    // one random word from the prng
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] hv_word_t;
    // item memory address, also the item_count width
    typedef logic [9:0] item_addr_t;
    // word slot inside one hypervector
    typedef logic [4:0] word_idx_t;

    // ------------------------------
    // register map
    // ------------------------------

    // {run, gen}
    localparam logic [11:0] REG_MODE       = 12'h000;
    // highest item index to generate
    localparam logic [11:0] REG_ITEM_COUNT = 12'h004;
    // region on addr 11:10 for item memory readout
    localparam logic [1:0]  ITEM_WINDOW    = 2'd1;

    // xorshift32 start state
    localparam hv_word_t XS_SEED = 32'd2463534242;

endpackage

/* hw/axil_slave_fsm.sv */
`timescale 1ns/10ps

module axil_slave_fsm
    import axil_pkg::*;
(
    input  logic        AXIS_ACLK,
    input  logic        S_AXI_ARESETN,
    input  axil_addr_t  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  axil_data_t  wdata,
    input  logic        wvalid,
    output logic        wready,
    input  logic        bready,
    output logic        bvalid,
    input  axil_addr_t  araddr,
    input  logic        arvalid,
    output logic        arready,
    input  logic        rready,
    output logic        rvalid,
    input  axil_data_t  rdata,
    output reg_wr_t     wr,
    output reg_rd_t     rd
);

    axil_state_e state;
    // latched write/read request
    logic [11:2] wr_addr_q;
    axil_data_t  wr_data_q;
    logic [11:2] rd_addr_q;
    // set after the first response cycle
    logic        wr_fired;

    // ------------------------------
    // channel handshakes
    // ------------------------------
    assign awready = (state == st_idle) || (state == st_w);
    assign wready  = (state == st_idle) || (state == st_aw);
    assign arready = (state == st_idle);
    assign bvalid  = (state == st_wresp);
    assign rvalid  = (state == st_rd_resp);

    // address and data in either order, write wins over read
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (awvalid && wvalid) begin
                        state <= st_wresp;
                    end else if (awvalid) begin
                        state <= st_aw;
                    end else if (wvalid) begin
                        state <= st_w;
                    end else if (arvalid) begin
                        state <= st_rd_fetch;
                    end
                end
                st_aw: begin
                    if (wvalid) begin
                        state <= st_wresp;
                    end
                end
                st_w: begin
                    if (awvalid) begin
                        state <= st_wresp;
                    end
                end
                st_wresp: begin
                    if (bready) begin
                        state <= st_idle;
                    end
                end
                // one fetch cycle then hold the response
                st_rd_fetch: state <= st_rd_resp;
                st_rd_resp: begin
                    if (rready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // capture on each accepted beat
    always_ff @(posedge AXIS_ACLK) begin
        if (awvalid && awready) begin
            wr_addr_q <= awaddr[11:2];
        end
        if (wvalid && wready) begin
            wr_data_q <= wdata;
        end
        if (arvalid && arready && !awvalid && !wvalid) begin
            rd_addr_q <= araddr[11:2];
        end
    end

    // write strobe only on the first wresp cycle
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            wr_fired <= 1'b0;
        end else begin
            wr_fired <= (state == st_wresp);
        end
    end

    assign wr = '{en: (state == st_wresp) && !wr_fired, addr: wr_addr_q, data: wr_data_q};
    assign rd = '{en: (state == st_rd_fetch), addr: rd_addr_q};

    // ------------------------------
    // checks
    // ------------------------------
    a_no_wr_rd_overlap: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN) !(wr.en && rd.en)
    ) else $error("register write and read strobes overlap");

endmodule

/* hw/hdc_regs.sv */
`timescale 1ns/10ps

module hdc_regs
    import axil_pkg::*;
    import hdc_pkg::*;
(
    input  logic       AXIS_ACLK,
    input  logic       S_AXI_ARESETN,
    input  reg_wr_t    wr,
    input  reg_rd_t    rd,
    input  logic       store,
    input  item_addr_t item_addr,
    input  hv_word_t   mem_word,
    output logic       gen,
    output logic       run,
    output item_addr_t mem_addr,
    output word_idx_t  mem_word_sel,
    output axil_data_t rdata
);

    // last item index to generate
    item_addr_t item_count;
    axil_data_t rd_mux;

    // ------------------------------
    // mode and count registers
    // ------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            run        <= 1'b0;
            gen        <= 1'b0;
            item_count <= '0;
        end else if (wr.en) begin
            // full compare, so other regions fall through
            if ({wr.addr, 2'b00} == REG_MODE) begin
                {run, gen} <= wr.data[1:0];
            end else if ({wr.addr, 2'b00} == REG_ITEM_COUNT) begin
                item_count <= wr.data[9:0];
            end
        end else if (gen && store && (item_addr == item_count)) begin
            // last vector stored, generation done
            gen <= 1'b0;
        end
    end

    // item window, entry on 9:4, word on 3:2
    assign mem_addr     = {4'b0000, rd.addr[9:4]};
    assign mem_word_sel = {3'b000, rd.addr[3:2]};

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb begin
        rd_mux = '0;
        if (rd.addr[11:10] == 2'd0) begin
            if ({rd.addr, 2'b00} == REG_MODE) begin
                rd_mux = {30'd0, run, gen};
            end else if ({rd.addr, 2'b00} == REG_ITEM_COUNT) begin
                rd_mux = {22'd0, item_count};
            end
        end else if (rd.addr[11:10] == ITEM_WINDOW) begin
            rd_mux = mem_word;
        end
    end

    // held through the response phase
    always_ff @(posedge AXIS_ACLK) begin
        if (rd.en) begin
            rdata <= rd_mux;
        end
    end

endmodule

/* hw/hv_word_counter.sv */
`timescale 1ns/10ps

module hv_word_counter
    import hdc_pkg::*;
#(
    parameter int DIM = 128
)(
    input  logic       AXIS_ACLK,
    input  logic       gen,
    output word_idx_t  word_idx,
    output logic       store,
    output item_addr_t item_addr
);

    // words per hypervector
    localparam int        W        = DIM / WORD_W;
    localparam word_idx_t LAST_IDX = word_idx_t'(W - 1);

    // slot counter, wraps once per vector
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            word_idx <= '0;
        end else if (word_idx == LAST_IDX) begin
            word_idx <= '0;
        end else begin
            word_idx <= word_idx + 1'b1;
        end
    end

    // store follows the last slot by one cycle
    always_ff @(posedge AXIS_ACLK) begin
        store <= gen && (word_idx == LAST_IDX);
    end

    // next entry after each store
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            item_addr <= '0;
        end else if (store) begin
            item_addr <= item_addr + 1'b1;
        end
    end

    a_store_one_cycle: assert property (
        @(posedge AXIS_ACLK) store |=> !store
    ) else $error("store held longer than one cycle");

endmodule

/* hw/xorshift_prng.sv */
`timescale 1ns/10ps

module xorshift_prng
    import hdc_pkg::*;
(
    input  logic     AXIS_ACLK,
    input  logic     gen,
    output hv_word_t rand_word
);

    hv_word_t xs_state;
    hv_word_t xs_a;
    hv_word_t xs_b;
    hv_word_t xs_next;

    // xorshift32, shifts 13 / 17 / 5
    always_comb begin
        xs_a    = xs_state ^ (xs_state << 13);
        xs_b    = xs_a ^ (xs_a >> 17);
        xs_next = xs_b ^ (xs_b << 5);
    end

    // back to seed whenever gen drops
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            xs_state <= XS_SEED;
        end else begin
            xs_state <= xs_next;
        end
    end

    assign rand_word = xs_state;

endmodule

/* hw/hv_assembler.sv */
`timescale 1ns/10ps

module hv_assembler
    import hdc_pkg::*;
#(
    parameter int DIM = 128
)(
    input  logic           AXIS_ACLK,
    input  logic           gen,
    input  word_idx_t      word_idx,
    input  hv_word_t       rand_word,
    output logic [DIM-1:0] hv
);

    // words per hypervector
    localparam int W = DIM / WORD_W;

    // one slot per cycle, slot chosen by the counter
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            hv <= '0;
        end else if (int'(word_idx) < W) begin
            hv[word_idx*WORD_W +: WORD_W] <= rand_word;
        end
    end

endmodule

/* hw/item_memory.sv */
`timescale 1ns/10ps

module item_memory
    import hdc_pkg::*;
#(
    parameter int DIM        = 128,
    parameter int ITEM_DEPTH = 16
)(
    input  logic           AXIS_ACLK,
    input  logic           store,
    input  item_addr_t     item_addr,
    input  logic [DIM-1:0] hv,
    input  item_addr_t     mem_addr,
    input  word_idx_t      mem_word_sel,
    output hv_word_t       mem_word
);

    localparam int W  = DIM / WORD_W;
    localparam int AW = $clog2(ITEM_DEPTH);

    logic [DIM-1:0] mem [ITEM_DEPTH];
    logic [DIM-1:0] rd_vec;

    // whole vector per store, out-of-range dropped
    always_ff @(posedge AXIS_ACLK) begin
        if (store && (item_addr < ITEM_DEPTH)) begin
            mem[item_addr[AW-1:0]] <= hv;
        end
    end

    // debug readout, zero outside the array
    always_comb begin
        rd_vec   = mem[mem_addr[AW-1:0]];
        mem_word = '0;
        if ((mem_addr < ITEM_DEPTH) && (int'(mem_word_sel) < W)) begin
            mem_word = rd_vec[mem_word_sel*WORD_W +: WORD_W];
        end
    end

    a_store_in_range: assert property (
        @(posedge AXIS_ACLK) store |-> (item_addr < ITEM_DEPTH)
    ) else $error("item store past ITEM_DEPTH dropped");

endmodule

/* hw/hdc_top.sv */
`timescale 1ns/10ps

module hdc_top
    import axil_pkg::*;
    import hdc_pkg::*;
#(
    parameter int DIM        = 128,
    parameter int ITEM_DEPTH = 16
)(
    input  logic       AXIS_ACLK,
    input  logic       S_AXI_ARESETN,
    // ------------------------------
    // AXI-Lite slave
    // ------------------------------
    input  axil_addr_t awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axil_data_t wdata,
    input  logic       wvalid,
    output logic       wready,
    input  logic       bready,
    output logic       bvalid,
    output logic [1:0] bresp,
    input  axil_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    input  logic       rready,
    output logic       rvalid,
    output axil_data_t rdata,
    output logic [1:0] rresp
);

    reg_wr_t        wr;
    reg_rd_t        rd;
    logic           gen;
    word_idx_t      word_idx;
    logic           store;
    item_addr_t     item_addr;
    hv_word_t       rand_word;
    logic [DIM-1:0] hv;
    item_addr_t     mem_addr;
    word_idx_t      mem_word_sel;
    hv_word_t       mem_word;

    // always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    axil_slave_fsm u_axil (
        .AXIS_ACLK(AXIS_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bready(bready), .bvalid(bvalid),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rready(rready), .rvalid(rvalid), .rdata(rdata),
        .wr(wr), .rd(rd)
    );

    // run is only stored, readable at 0x00
    hdc_regs u_regs (
        .AXIS_ACLK(AXIS_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
        .wr(wr), .rd(rd), .store(store), .item_addr(item_addr),
        .mem_word(mem_word), .gen(gen), .run(),
        .mem_addr(mem_addr), .mem_word_sel(mem_word_sel), .rdata(rdata)
    );

    // ------------------------------
    // generation path, driven by gen
    // ------------------------------
    hv_word_counter #(.DIM(DIM)) u_cnt (
        .AXIS_ACLK(AXIS_ACLK), .gen(gen),
        .word_idx(word_idx), .store(store), .item_addr(item_addr)
    );

    xorshift_prng u_prng (
        .AXIS_ACLK(AXIS_ACLK), .gen(gen), .rand_word(rand_word)
    );

    hv_assembler #(.DIM(DIM)) u_asm (
        .AXIS_ACLK(AXIS_ACLK), .gen(gen),
        .word_idx(word_idx), .rand_word(rand_word), .hv(hv)
    );

    item_memory #(.DIM(DIM), .ITEM_DEPTH(ITEM_DEPTH)) u_mem (
        .AXIS_ACLK(AXIS_ACLK), .store(store), .item_addr(item_addr), .hv(hv),
        .mem_addr(mem_addr), .mem_word_sel(mem_word_sel), .mem_word(mem_word)
    );

endmodule

/* verif/tb_hdc_top.sv */
`timescale 1ns/10ps

module tb_hdc_top;

    localparam int          DIM         = 128;
    localparam int          ITEM_DEPTH  = 16;
    localparam int          WORDS       = DIM / 32;
    localparam logic [11:0] MODE_ADDR   = 12'h000;
    localparam logic [11:0] COUNT_ADDR  = 12'h004;
    localparam logic [11:0] ITEM_BASE   = 12'h400;
    localparam logic [31:0] XS_START    = 32'd2463534242;
    localparam logic [15:0] LFSR_SEED   = 16'd19330;
    localparam int          WAIT_LIMIT  = 50;
    localparam int          POLL_LIMIT  = 100;

    logic        AXIS_ACLK;
    logic        S_AXI_ARESETN;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic        bready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic        rready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic [15:0] lfsr_state;

    hdc_top #(.DIM(DIM), .ITEM_DEPTH(ITEM_DEPTH)) dut_i (
        .AXIS_ACLK(AXIS_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bready(bready), .bvalid(bvalid), .bresp(bresp),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rready(rready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp)
    );

    // 100 ns period
    initial begin
        AXIS_ACLK = 1'b0;
        forever #50 AXIS_ACLK = ~AXIS_ACLK;
    end

    // ------------------------------
    // checks and random source
    // ------------------------------
    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            $display("Something failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timed out at %0t ns while waiting for %s", $time, what);
        $display("Something failed");
        $fatal(1, "stopping on timeout");
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // reference xorshift32 step
    function automatic logic [31:0] xs_step(input logic [31:0] x);
        logic [31:0] t;
        t = x ^ (x << 13);
        t = t ^ (t >> 17);
        xs_step = t ^ (t << 5);
    endfunction

    // ------------------------------
    // AXI-Lite master tasks
    // ------------------------------
    // order 0 together, 1 address first, 2 data first
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data, input int order);
        int t;
        int beat;
        int beats;
        beats = (order == 0) ? 1 : 2;
        @(posedge AXIS_ACLK);
        awaddr  <= addr;
        wdata   <= data;
        bready  <= 1'b1;
        awvalid <= (order != 2);
        wvalid  <= (order != 1);
        for (beat = 0; beat < beats; beat++) begin
            t = 0;
            do begin
                @(negedge AXIS_ACLK);
                t++;
                if (t > WAIT_LIMIT) fail_timeout("write address or data ready");
            end while ((awvalid && !awready) || (wvalid && !wready));
            // channel taken in the first beat is no longer ready
            if (beat == 1) begin
                check_equal({31'd0, ((order == 1) ? awready : wready)}, 32'd0,
                            "ready of the channel already accepted");
            end
            // second channel goes up once the first is taken
            @(posedge AXIS_ACLK);
            awvalid <= (beat == 0) && (order == 2);
            wvalid  <= (beat == 0) && (order == 1);
        end
        t = 0;
        do begin
            @(negedge AXIS_ACLK);
            t++;
            if (t > WAIT_LIMIT) fail_timeout("write response valid");
        end while (!bvalid);
        check_equal({30'd0, bresp}, 32'd0, "write response code");
        check_equal({30'd0, awready, wready}, 32'd0, "write ready during response");
        @(posedge AXIS_ACLK);
        bready <= 1'b0;
    endtask

    // rready held low for hold cycles after rvalid
    task automatic axil_read(input logic [11:0] addr, input int hold, output logic [31:0] data);
        int t;
        int i;
        @(posedge AXIS_ACLK);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b0;
        t = 0;
        do begin
            @(negedge AXIS_ACLK);
            t++;
            if (t > WAIT_LIMIT) fail_timeout("read address ready");
        end while (!arready);
        @(posedge AXIS_ACLK);
        arvalid <= 1'b0;
        t = 0;
        do begin
            @(negedge AXIS_ACLK);
            t++;
            if (t > WAIT_LIMIT) fail_timeout("read data valid");
        end while (!rvalid);
        data = rdata;
        check_equal({30'd0, rresp}, 32'd0, "read response code");
        check_equal({31'd0, arready}, 32'd0, "arready during read response");
        // back-pressure, response must hold
        for (i = 0; i < hold; i++) begin
            @(negedge AXIS_ACLK);
            check_equal({31'd0, rvalid}, 32'd1, "rvalid under back-pressure");
            check_equal(rdata, data, "rdata under back-pressure");
        end
        @(posedge AXIS_ACLK);
        rready <= 1'b1;
        @(negedge AXIS_ACLK);
        check_equal(rdata, data, "rdata at handshake");
        @(posedge AXIS_ACLK);
        rready <= 1'b0;
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic reset_values_test();
        logic [31:0] v;
        axil_read(MODE_ADDR, 0, v);
        check_equal(v, 32'd0, "mode after reset");
        axil_read(COUNT_ADDR, 0, v);
        check_equal(v, 32'd0, "item count after reset");
    endtask

    task automatic register_access_test();
        logic [31:0] v;
        logic [31:0] cnt_val [3];
        int order;
        cnt_val[0] = 32'hABCD_E3F5;
        cnt_val[1] = 32'h0000_0007;
        cnt_val[2] = 32'h1234_5A0C;
        for (order = 0; order < 3; order++) begin
            axil_write(MODE_ADDR, 32'h2, order);
            axil_read(MODE_ADDR, 0, v);
            check_equal(v, 32'h2, $sformatf("mode readback, order %0d", order));
            axil_write(COUNT_ADDR, cnt_val[order], order);
            axil_read(COUNT_ADDR, 0, v);
            check_equal(v, cnt_val[order] & 32'h3FF, $sformatf("count readback, order %0d", order));
        end
    endtask

    // last count written above was 0x20C
    task automatic unmapped_write_test();
        logic [31:0] v;
        axil_write(12'h008, 32'hFFFF_FFFF, 0);
        axil_write(12'h3FC, 32'hFFFF_FFFF, 1);
        axil_read(12'h008, 0, v);
        check_equal(v, 32'd0, "unmapped read");
        axil_read(MODE_ADDR, 0, v);
        check_equal(v, 32'h2, "mode after unmapped write");
        axil_read(COUNT_ADDR, 0, v);
        check_equal(v, 32'h20C, "count after unmapped write");
    endtask

    task automatic generation_test();
        logic [31:0] n;
        logic [31:0] v;
        logic [31:0] x;
        logic [31:0] hold;
        int polls;
        int e;
        int w;
        take_bits(4, n);
        axil_write(COUNT_ADDR, n, 0);
        axil_write(MODE_ADDR, 32'h1, 2);
        // poll until gen drops
        polls = 0;
        do begin
            axil_read(MODE_ADDR, 0, v);
            polls++;
            if (polls > POLL_LIMIT) fail_timeout("gen to clear");
        end while (v[0]);
        check_equal(v, 32'd0, "mode after generation");
        // entry e word w is the seed stepped e*W+w times
        x = XS_START;
        for (e = 0; e <= int'(n); e++) begin
            for (w = 0; w < WORDS; w++) begin
                take_bits(2, hold);
                axil_read(ITEM_BASE | 12'(e << 4) | 12'(w << 2), int'(hold), v);
                check_equal(v, x, $sformatf("item %0d word %0d of %0d", e, w, n));
                x = xs_step(x);
            end
        end
    endtask

    initial begin
        S_AXI_ARESETN = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        lfsr_state    = LFSR_SEED;
        repeat (10) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;
        reset_values_test();
        register_access_test();
        unmapped_write_test();
        // two rounds with fresh counts
        generation_test();
        generation_test();
        $display("Everything OK");
        $finish;
    end

endmodule

/* project.f */
hw/axil_pkg.sv
hw/hdc_pkg.sv
hw/axil_slave_fsm.sv
hw/hdc_regs.sv
hw/hv_word_counter.sv
hw/xorshift_prng.sv
hw/hv_assembler.sv
hw/item_memory.sv
hw/hdc_top.sv
verif/tb_hdc_top.sv

/* Makefile */
TOP := tb_hdc_top
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module hdc_top -f project.f

clean:
	rm -rf obj_dir $(LOG)
